/* Makefile */
# Verilator build and run for the LCD controller testbench

VERILATOR ?= verilator
TOP       ?= lcd_ctrl_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS    := $(wildcard verilog/*.sv verif/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
verilog/lcd_pkg.sv
verilog/lcd_bus_writer.sv
verilog/lcd_cmd_sequencer.sv
verilog/lcd_ctrl_top.sv
verif/lcd_bus_monitor.sv
verif/lcd_ctrl_tb.sv

/* verif/lcd_bus_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_monitor (
    input logic              clk,
    input logic              nrst,
    input lcd_pkg::lcd_bus_t lcd
);

    logic [8:0] cap_q[$];       // {dcx, data} for every latched byte
    int         bus_errors = 0;
    logic       wrx_q;

    // a rising wrx shows up one clock later, data and csx are still held then
    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wrx_q <= 1'b1;      // reset pulls wrx high, not a strobe
        end else begin
            wrx_q <= lcd.wrx;
            if (lcd.wrx && !wrx_q) begin
                cap_q.push_back({lcd.dcx, lcd.data});
                if (lcd.csx) begin
                    bus_errors++;
                    $display("Bus error at %0t: wrx rose while csx was high", $time);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verif/lcd_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl_tb;

    localparam int CLK_PERIOD = 100;
    // 1 + 6 + 4 + 8 random of up to 16 + 16 + 2
    localparam int MAX_PIXELS     = 157;
    localparam int TIMEOUT_CYCLES = MAX_PIXELS * 7 + 2000;

    logic               clk = 1'b0;
    logic               nrst;
    logic               fill_start;
    lcd_pkg::fill_req_t fill_req;
    logic               ready;
    logic               fill_done;
    lcd_pkg::lcd_bus_t  lcd;
    logic [8:0]         exp_q[$];   // expected {dcx, data}
    int                 errors = 0;

    lcd_ctrl_top #(
        .HALF_CYCLES       (1),
        .RESET_WAIT_CYCLES (8)
    ) dut_i (
        .clk        (clk),
        .nrst       (nrst),
        .fill_start (fill_start),
        .fill_req   (fill_req),
        .ready      (ready),
        .fill_done  (fill_done),
        .lcd        (lcd)
    );

    lcd_bus_monitor mon_i (
        .clk  (clk),
        .nrst (nrst),
        .lcd  (lcd)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // opcode with dcx low, then n parameter bytes from the top down
    task automatic push_cmd(input lcd_pkg::byte_t op, input logic [31:0] params, input int n);
        exp_q.push_back({1'b0, op});
        for (int i = 0; i < n; i++) begin
            exp_q.push_back({1'b1, params[31 - 8 * i -: 8]});
        end
    endtask

    task automatic expect_startup();
        push_cmd(lcd_pkg::CMD_SWRESET, 32'h0, 0);
        push_cmd(lcd_pkg::CMD_PIXFMT, {lcd_pkg::PIXFMT_16BPP, 24'h0}, 1);
        push_cmd(lcd_pkg::CMD_DISPON, 32'h0, 0);
    endtask

    task automatic expect_fill(input lcd_pkg::fill_req_t r);
        int npix;
        npix = (int'(r.x1) - int'(r.x0) + 1) * (int'(r.y1) - int'(r.y0) + 1);
        push_cmd(lcd_pkg::CMD_CASET, {r.x0, r.x1}, 4);
        push_cmd(lcd_pkg::CMD_PASET, {r.y0, r.y1}, 4);
        push_cmd(lcd_pkg::CMD_RAMWR, {r.color, 16'h0}, 2);
        for (int i = 1; i < npix; i++) begin
            push_cmd(lcd_pkg::CMD_RAMWRC, {r.color, 16'h0}, 2);
        end
    endtask

    // compare captured bytes from index start with exp_q and empty it
    task automatic check_stream(input int start, input string name);
        int got;
        got = mon_i.cap_q.size() - start;
        if (got != exp_q.size()) begin
            errors++;
            $display("Mismatch at %0t: %s byte count expected %0d actual %0d",
                     $time, name, exp_q.size(), got);
        end
        for (int i = 0; i < exp_q.size() && i < got; i++) begin
            if (mon_i.cap_q[start + i] !== exp_q[i]) begin
                errors++;
                $display("Mismatch at %0t: %s lcd.dcx/lcd.data[%0d] expected %0b/%02h actual %0b/%02h",
                         $time, name, i, exp_q[i][8], exp_q[i][7:0],
                         mon_i.cap_q[start + i][8], mon_i.cap_q[start + i][7:0]);
            end
        end
        exp_q.delete();
    endtask

    task automatic apply_reset();
        @(negedge clk);
        nrst = 1'b0;
        repeat (4) @(negedge clk);
        if (lcd.csx !== 1'b1 || lcd.wrx !== 1'b1) begin
            errors++;
            $display("Mismatch at %0t: lcd.csx/lcd.wrx expected 1/1 actual %0b/%0b",
                     $time, lcd.csx, lcd.wrx);
        end
        if (ready !== 1'b0) begin
            errors++;
            $display("Mismatch at %0t: ready expected 0 actual %0b", $time, ready);
        end
        nrst = 1'b1;
    endtask

    task automatic test_startup();
        int start;
        int n;
        apply_reset();
        start = mon_i.cap_q.size();
        expect_startup();
        n = 0;
        while (ready !== 1'b1 && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (ready !== 1'b1) begin
            errors++;
            $display("ready never rose after reset");
        end
        check_stream(start, "startup");
    endtask

    // inject pulses a second fill_start while the first fill runs
    task automatic run_fill(input lcd_pkg::fill_req_t r, input bit inject, input string name);
        int start;
        int pulses;
        int n;
        lcd_pkg::fill_req_t other;
        start = mon_i.cap_q.size();
        expect_fill(r);
        @(negedge clk);
        fill_req   = r;
        fill_start = 1'b1;
        @(negedge clk);
        fill_start = 1'b0;
        pulses     = 0;
        if (ready !== 1'b0) begin   // accepted request drops ready
            errors++;
            $display("Mismatch at %0t: %s ready expected 0 actual %0b", $time, name, ready);
        end
        if (inject) begin
            repeat (5) @(negedge clk);
            if (ready !== 1'b0) begin
                errors++;
                $display("Mismatch at %0t: %s ready expected 0 actual %0b",
                         $time, name, ready);
            end
            other       = r;
            other.x1    = r.x1 + 16'd3;
            other.color = ~r.color;
            fill_req    = other;
            fill_start  = 1'b1;
            @(negedge clk);
            fill_start  = 1'b0;
            pulses      = fill_done ? 1 : 0;
        end
        n = 0;
        while (pulses == 0 && n < 4000) begin
            @(negedge clk);
            if (fill_done) begin
                pulses++;
                if (ready !== 1'b1) begin   // ready comes back with fill_done
                    errors++;
                    $display("Mismatch at %0t: %s ready expected 1 actual %0b",
                             $time, name, ready);
                end
            end
            n++;
        end
        if (pulses == 0) begin
            errors++;
            $display("%s never pulsed fill_done", name);
        end
        repeat (30) begin      // a late pulse or stray bytes would show here
            @(negedge clk);
            if (fill_done) pulses++;
        end
        if (pulses != 1) begin
            errors++;
            $display("Mismatch at %0t: %s fill_done pulses expected 1 actual %0d",
                     $time, name, pulses);
        end
        check_stream(start, name);
    endtask

    task automatic test_random_windows();
        lcd_pkg::fill_req_t r;
        for (int i = 0; i < 8; i++) begin
            r.x0    = 16'($urandom_range(0, 235));
            r.x1    = r.x0 + 16'($urandom_range(0, 3));
            r.y0    = 16'($urandom_range(0, 315));
            r.y1    = r.y0 + 16'($urandom_range(0, 3));
            r.color = 16'($urandom);
            run_fill(r, 1'b0, "random");
        end
    endtask

    task automatic test_reset_mid_fill();
        @(negedge clk);
        fill_req   = '{x0: 16'd10, x1: 16'd13, y0: 16'd20, y1: 16'd23, color: 16'h07e0};
        fill_start = 1'b1;
        @(negedge clk);
        fill_start = 1'b0;
        repeat (40) @(negedge clk);     // well inside the pixel stream
        if (ready !== 1'b0) begin
            errors++;
            $display("Mismatch at %0t: ready before reset expected 0 actual %0b",
                     $time, ready);
        end
        test_startup();
        run_fill('{x0: 16'd0, x1: 16'd1, y0: 16'd5, y1: 16'd5, color: 16'h1234},
                 1'b0, "after reset");
    endtask

    initial begin
        void'($urandom(32'hfc45_5578));
        nrst       = 1'b0;
        fill_start = 1'b0;
        fill_req   = '0;
        test_startup();
        run_fill('{x0: 16'd5, x1: 16'd5, y0: 16'd300, y1: 16'd300, color: 16'hf81f},
                 1'b0, "single pixel");
        run_fill('{x0: 16'h0102, x1: 16'h0104, y0: 16'd7, y1: 16'd8, color: 16'hab3c},
                 1'b0, "3x2 rectangle");
        run_fill('{x0: 16'd40, x1: 16'd41, y0: 16'd50, y1: 16'd51, color: 16'h5a5a},
                 1'b1, "busy start");
        test_random_windows();
        test_reset_mid_fill();
        $display("errors: %0d check, %0d bus", errors, mon_i.bus_errors);
        if (errors == 0 && mon_i.bus_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog scaled to the pixel total
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/lcd_bus_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_writer #(
    parameter int HALF_CYCLES = 1
) (
    input  logic              clk,
    input  logic              nrst,
    input  logic              cmd_start,
    input  lcd_pkg::lcd_cmd_t cmd,
    output logic              cmd_busy,
    output logic              cmd_done,
    output lcd_pkg::lcd_bus_t lcd
);

    localparam int TW = (HALF_CYCLES > 1) ? $clog2(HALF_CYCLES) : 1;
    localparam logic [TW-1:0] HALF_LAST = TW'(HALF_CYCLES - 1);

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_CMD,     // command byte, wrx low
        WR_STROBE,  // wrx high, byte gets latched
        WR_PARAM,   // parameter byte, wrx low
        WR_FINISH
    } wr_state_t;

    wr_state_t             state;
    logic [TW-1:0]         half_cnt;
    logic                  half_end;
    logic                  next_byte;
    lcd_pkg::param_t       param_sr;
    lcd_pkg::param_count_t param_total;
    lcd_pkg::param_count_t param_sent;
    lcd_pkg::param_count_t table_count;

    // parameter count per opcode
    always_comb begin
        case (cmd.opcode)
            lcd_pkg::CMD_CASET,
            lcd_pkg::CMD_PASET: begin
                table_count = 3'd4;
            end
            lcd_pkg::CMD_PIXFMT: begin
                table_count = 3'd1;
            end
            lcd_pkg::CMD_RAMWR: begin
                table_count = 3'd2;
            end
            lcd_pkg::CMD_SWRESET,
            lcd_pkg::CMD_DISPON,
            lcd_pkg::CMD_DISPOFF,
            lcd_pkg::CMD_NOP: begin
                table_count = 3'd0;
            end
            default: begin
                // caller supplied, never more than four
                table_count = (cmd.param_count > 3'd4) ? 3'd4 : cmd.param_count;
            end
        endcase
    end

    assign half_end  = (half_cnt == HALF_LAST);
    assign next_byte = (state == WR_STROBE) && half_end && (param_sent != param_total);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state       <= WR_IDLE;
            half_cnt    <= '0;
            param_total <= '0;
            param_sent  <= '0;
            lcd.data    <= '0;
            lcd.csx     <= 1'b1;
            lcd.dcx     <= 1'b0;
            lcd.wrx     <= 1'b1;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (cmd_start) begin
                        state       <= WR_CMD;
                        half_cnt    <= '0;
                        param_total <= table_count;
                        param_sent  <= '0;
                        lcd.data    <= cmd.opcode;
                        lcd.csx     <= 1'b0;
                        lcd.dcx     <= 1'b0;
                        lcd.wrx     <= 1'b0;
                    end
                end
                WR_CMD, WR_PARAM: begin
                    if (half_end) begin
                        half_cnt <= '0;
                        state    <= WR_STROBE;
                        lcd.wrx  <= 1'b1;   // rising edge latches the byte
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                WR_STROBE: begin
                    if (half_end) begin
                        half_cnt <= '0;
                        if (next_byte) begin
                            state      <= WR_PARAM;
                            param_sent <= param_sent + 1'b1;
                            lcd.data   <= param_sr[31:24];
                            lcd.dcx    <= 1'b1;
                            lcd.wrx    <= 1'b0;
                        end else begin
                            state   <= WR_FINISH;
                            lcd.csx <= 1'b1;
                        end
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                WR_FINISH: state <= WR_IDLE;
                default:   state <= WR_IDLE;
            endcase
        end
    end

    // parameter bytes, top byte first
    always_ff @(posedge clk) begin
        if (state == WR_IDLE && cmd_start) begin
            param_sr <= cmd.params;
        end else if (next_byte) begin
            param_sr <= {param_sr[23:0], 8'h00};
        end
    end

    assign cmd_busy = state inside {WR_CMD, WR_STROBE, WR_PARAM};
    assign cmd_done = (state == WR_FINISH);

endmodule

`default_nettype wire

/* verilog/lcd_cmd_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_cmd_sequencer #(
    parameter int RESET_WAIT_CYCLES = 16
) (
    input  logic               clk,
    input  logic               nrst,
    input  logic               fill_start,
    input  lcd_pkg::fill_req_t fill_req,
    output logic               ready,
    output logic               fill_done,
    output logic               cmd_start,
    output lcd_pkg::lcd_cmd_t  cmd,
    input  logic               cmd_busy,
    input  logic               cmd_done
);

    localparam int WW = $clog2(RESET_WAIT_CYCLES + 1);

    typedef enum logic [3:0] {
        SQ_SWRESET,
        SQ_RST_WAIT,
        SQ_PIXFMT,
        SQ_DISPON,
        SQ_IDLE,
        SQ_CASET,    // column window
        SQ_PASET,    // page window
        SQ_RAMWR,    // first pixel
        SQ_RAMWRC    // remaining pixels
    } seq_state_t;

    seq_state_t            state;
    logic                  issued;     // command of this state already handed over
    logic                  cmd_state;
    logic [WW-1:0]         wait_cnt;
    lcd_pkg::fill_req_t    req_q;
    lcd_pkg::coord_t       width;
    lcd_pkg::coord_t       height;
    lcd_pkg::pixel_count_t pix_total;
    lcd_pkg::pixel_count_t pix_left;
    logic                  last_pixel;

    assign width      = fill_req.x1 - fill_req.x0 + 16'd1;
    assign height     = fill_req.y1 - fill_req.y0 + 16'd1;
    assign pix_total  = lcd_pkg::pixel_count_t'(width) * lcd_pkg::pixel_count_t'(height);
    assign last_pixel = (pix_left == 32'd1);

    assign cmd_state = state inside {SQ_SWRESET, SQ_PIXFMT, SQ_DISPON,
                                     SQ_CASET, SQ_PASET, SQ_RAMWR, SQ_RAMWRC};
    assign ready     = (state == SQ_IDLE);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= SQ_SWRESET;
            issued    <= 1'b0;
            cmd_start <= 1'b0;
            fill_done <= 1'b0;
            wait_cnt  <= '0;
            pix_left  <= '0;
        end else begin
            cmd_start <= 1'b0;
            fill_done <= 1'b0;
            if (cmd_state && !issued && !cmd_busy) begin
                cmd_start <= 1'b1;
                issued    <= 1'b1;
            end
            if (cmd_done) begin
                issued <= 1'b0;
            end
            case (state)
                SQ_SWRESET: begin
                    if (cmd_done) begin
                        state    <= SQ_RST_WAIT;
                        wait_cnt <= '0;
                    end
                end
                SQ_RST_WAIT: begin
                    // panel needs quiet time after a software reset
                    if (wait_cnt == WW'(RESET_WAIT_CYCLES - 1)) begin
                        state <= SQ_PIXFMT;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                SQ_PIXFMT: if (cmd_done) state <= SQ_DISPON;
                SQ_DISPON: if (cmd_done) state <= SQ_IDLE;
                SQ_IDLE: begin
                    if (fill_start) begin
                        state    <= SQ_CASET;
                        pix_left <= pix_total;
                    end
                end
                SQ_CASET: if (cmd_done) state <= SQ_PASET;
                SQ_PASET: if (cmd_done) state <= SQ_RAMWR;
                SQ_RAMWR, SQ_RAMWRC: begin
                    if (cmd_done) begin
                        if (last_pixel) begin
                            state     <= SQ_IDLE;
                            fill_done <= 1'b1;
                        end else begin
                            state    <= SQ_RAMWRC;
                            pix_left <= pix_left - 1'b1;
                        end
                    end
                end
                default: state <= SQ_SWRESET;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SQ_IDLE && fill_start) begin
            req_q <= fill_req;
        end
    end

    // command for the current step, steady until its cmd_done
    always_comb begin
        cmd.opcode      = lcd_pkg::CMD_NOP;
        cmd.params      = '0;
        cmd.param_count = 3'd0;
        case (state)
            SQ_SWRESET: cmd.opcode = lcd_pkg::CMD_SWRESET;
            SQ_PIXFMT: begin
                cmd.opcode      = lcd_pkg::CMD_PIXFMT;
                cmd.params      = {lcd_pkg::PIXFMT_16BPP, 24'h000000};
                cmd.param_count = 3'd1;
            end
            SQ_DISPON: cmd.opcode = lcd_pkg::CMD_DISPON;
            SQ_CASET: begin
                cmd.opcode      = lcd_pkg::CMD_CASET;
                cmd.params      = {req_q.x0, req_q.x1};   // start then end, high byte first
                cmd.param_count = 3'd4;
            end
            SQ_PASET: begin
                cmd.opcode      = lcd_pkg::CMD_PASET;
                cmd.params      = {req_q.y0, req_q.y1};
                cmd.param_count = 3'd4;
            end
            SQ_RAMWR: begin
                cmd.opcode      = lcd_pkg::CMD_RAMWR;
                cmd.params      = {req_q.color, 16'h0000};
                cmd.param_count = 3'd2;
            end
            SQ_RAMWRC: begin
                cmd.opcode      = lcd_pkg::CMD_RAMWRC;
                cmd.params      = {req_q.color, 16'h0000};
                cmd.param_count = 3'd2;    // not in the writer table
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/lcd_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl_top #(
    parameter int HALF_CYCLES       = 1,
    parameter int RESET_WAIT_CYCLES = 16
) (
    input  logic               clk,
    input  logic               nrst,
    input  logic               fill_start,
    input  lcd_pkg::fill_req_t fill_req,
    output logic               ready,
    output logic               fill_done,
    output lcd_pkg::lcd_bus_t  lcd
);

    // sequencer to writer
    logic              cmd_start;
    lcd_pkg::lcd_cmd_t cmd;
    logic              cmd_busy;
    logic              cmd_done;

    lcd_cmd_sequencer #(
        .RESET_WAIT_CYCLES (RESET_WAIT_CYCLES)
    ) seq_i (
        .clk        (clk),
        .nrst       (nrst),
        .fill_start (fill_start),
        .fill_req   (fill_req),
        .ready      (ready),
        .fill_done  (fill_done),
        .cmd_start  (cmd_start),
        .cmd        (cmd),
        .cmd_busy   (cmd_busy),
        .cmd_done   (cmd_done)
    );

    lcd_bus_writer #(
        .HALF_CYCLES (HALF_CYCLES)
    ) writer_i (
        .clk       (clk),
        .nrst      (nrst),
        .cmd_start (cmd_start),
        .cmd       (cmd),
        .cmd_busy  (cmd_busy),
        .cmd_done  (cmd_done),
        .lcd       (lcd)
    );

endmodule

`default_nettype wire

/* verilog/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] coord_t;        // panel column or row
    typedef logic [15:0] color_t;        // rgb565
    typedef logic [31:0] param_t;        // up to four bytes, top byte goes first
    typedef logic [2:0]  param_count_t;
    typedef logic [31:0] pixel_count_t;

    // one command as handed to the bus writer
    typedef struct packed {
        byte_t        opcode;
        param_t       params;
        param_count_t param_count;  // only for opcodes outside the writer table
    } lcd_cmd_t;

    typedef struct packed {
        coord_t x0;
        coord_t x1;
        coord_t y0;
        coord_t y1;
        color_t color;
    } fill_req_t;

    // panel side pins, rdx is tied high on the board
    typedef struct packed {
        byte_t data;
        logic  csx;
        logic  dcx;   // 0 command, 1 parameter
        logic  wrx;   // panel latches on the rising edge
    } lcd_bus_t;

    localparam byte_t CMD_NOP     = 8'h00;
    localparam byte_t CMD_SWRESET = 8'h01;
    localparam byte_t CMD_DISPOFF = 8'h28;
    localparam byte_t CMD_DISPON  = 8'h29;
    localparam byte_t CMD_CASET   = 8'h2A;
    localparam byte_t CMD_PASET   = 8'h2B;
    localparam byte_t CMD_RAMWR   = 8'h2C;
    localparam byte_t CMD_PIXFMT  = 8'h3A;
    localparam byte_t CMD_RAMWRC  = 8'h3C;

    localparam byte_t PIXFMT_16BPP = 8'h55;

endpackage

`default_nettype wire
